/* logic/vec_alu_defines.svh */
`ifndef VEC_ALU_DEFINES_SVH
`define VEC_ALU_DEFINES_SVH

// Operand word
`define VEC_BITS 64

// Function code field
`define FUNC_BITS 6

// Lane width field
`define WW_BITS 2

`endif

/* logic/vec_alu_pkg.sv */
`include "vec_alu_defines.svh"

package vec_alu_pkg;

	// Function codes
	// 14, 15 and 18 were divide, modulo and square root, now unsupported
	typedef enum logic [0:`FUNC_BITS-1] {
		VNOP   = 6'd0,
		VAND   = 6'd1,
		VOR    = 6'd2,
		VXOR   = 6'd3,
		VNOT   = 6'd4,
		VMOV   = 6'd5,
		VADD   = 6'd6,
		VSUB   = 6'd7,
		VMULEU = 6'd8,
		VMULOU = 6'd9,
		VSLL   = 6'd10,
		VSRL   = 6'd11,
		VSRA   = 6'd12,
		VRTTH  = 6'd13,
		VSQEU  = 6'd16,
		VSQOU  = 6'd17
	} func_e;

	// Lane width select
	typedef enum logic [0:`WW_BITS-1] {
		W8  = 2'd0,
		W16 = 2'd1,
		W32 = 2'd2,
		W64 = 2'd3
	} lane_width_e;

	// One operand word seen as lanes of each width
	// Bit 0 is the MSB and index 0 is the most significant lane
	typedef union packed {
		logic [0:`VEC_BITS/8-1][0:7]   b;
		logic [0:`VEC_BITS/16-1][0:15] h;
		logic [0:`VEC_BITS/32-1][0:31] w;
		logic [0:`VEC_BITS/64-1][0:63] d;
	} vec_word_u;

endpackage

/* logic/lane_logic_unit.sv */
`include "vec_alu_defines.svh"

module lane_logic_unit (
	input  vec_alu_pkg::func_e       func,
	input  vec_alu_pkg::lane_width_e width,
	input  vec_alu_pkg::vec_word_u   op_a,
	input  vec_alu_pkg::vec_word_u   op_b,
	output vec_alu_pkg::vec_word_u   result,
	output logic                     claim
);

	import vec_alu_pkg::*;

	localparam int SHW = $clog2(`VEC_BITS);

	// One lane held right aligned in a full word, upper bits zero
	function automatic logic [0:`VEC_BITS-1] lane_op(
		input func_e                f,
		input int unsigned          bits,
		input logic [0:`VEC_BITS-1] a,
		input logic [0:`VEC_BITS-1] b
	);
		logic [0:`VEC_BITS-1] mask;
		logic [0:`VEC_BITS-1] sext;
		logic [0:`VEC_BITS-1] r;
		logic [0:SHW-1]       amt;

		// Shift by full width gives zero, so the 64 bit mask is all ones
		mask = ~({`VEC_BITS{1'b1}} << bits);

		// Only the low log2(bits) bits of the B lane count
		amt = SHW'(b) & SHW'(bits - 1);

		// Lane sign bit copied into the unused upper bits
		sext = a[`VEC_BITS - bits] ? (a | ~mask) : a;

		case (f)
			VADD: begin
				r = a + b;
			end
			VSUB: begin
				r = a - b;
			end
			VSLL: begin
				r = a << amt;
			end
			VSRL: begin
				r = a >> amt;
			end
			VSRA: begin
				r = $signed(sext) >>> amt;
			end
			VRTTH: begin
				r = (a << (bits / 2)) | (a >> (bits / 2));
			end
			default: begin
				r = '0;
			end
		endcase

		// Carries and shifted-out bits stay inside the lane
		return r & mask;
	endfunction

	// Apply lane_op to every lane of the selected view
	function automatic vec_word_u lane_word(
		input func_e       f,
		input lane_width_e ww,
		input vec_word_u   a,
		input vec_word_u   b
	);
		vec_word_u r;

		r = '0;
		case (ww)
			W8: begin
				for (int i = 0; i < `VEC_BITS / 8; i++) begin
					r.b[i] = 8'(lane_op(f, 8, `VEC_BITS'(a.b[i]), `VEC_BITS'(b.b[i])));
				end
			end
			W16: begin
				for (int i = 0; i < `VEC_BITS / 16; i++) begin
					r.h[i] = 16'(lane_op(f, 16, `VEC_BITS'(a.h[i]), `VEC_BITS'(b.h[i])));
				end
			end
			W32: begin
				for (int i = 0; i < `VEC_BITS / 32; i++) begin
					r.w[i] = 32'(lane_op(f, 32, `VEC_BITS'(a.w[i]), `VEC_BITS'(b.w[i])));
				end
			end
			default: begin
				r.d[0] = lane_op(f, 64, a.d[0], b.d[0]);
			end
		endcase
		return r;
	endfunction

	always_comb begin
		claim = 1'b1;
		result = '0;
		case (func)
			// Bitwise functions ignore lane boundaries
			VAND: begin
				result = op_a & op_b;
			end
			VOR: begin
				result = op_a | op_b;
			end
			VXOR: begin
				result = op_a ^ op_b;
			end
			VNOT: begin
				result = ~op_a;
			end
			VMOV: begin
				result = op_a;
			end
			VADD, VSUB, VSLL, VSRL, VSRA, VRTTH: begin
				result = lane_word(func, width, op_a, op_b);
			end
			default: begin
				claim = 1'b0;
			end
		endcase
	end

endmodule

/* logic/lane_mul_unit.sv */
`include "vec_alu_defines.svh"

module lane_mul_unit (
	input  vec_alu_pkg::func_e       func,
	input  vec_alu_pkg::lane_width_e width,
	input  vec_alu_pkg::vec_word_u   op_a,
	input  vec_alu_pkg::vec_word_u   op_b,
	output vec_alu_pkg::vec_word_u   result,
	output logic                     claim
);

	import vec_alu_pkg::*;

	logic      odd;
	logic      square;
	vec_word_u op_m;

	// Even or odd lanes, B or A itself as multiplier
	always_comb begin
		claim = 1'b1;
		odd = 1'b0;
		square = 1'b0;
		case (func)
			VMULEU: begin
				odd = 1'b0;
			end
			VMULOU: begin
				odd = 1'b1;
			end
			VSQEU: begin
				square = 1'b1;
			end
			VSQOU: begin
				odd = 1'b1;
				square = 1'b1;
			end
			default: begin
				claim = 1'b0;
			end
		endcase
	end

	assign op_m = square ? op_a : op_b;

	// Product i lands in lane i of the next wider view
	always_comb begin
		result = '0;
		if (claim) begin
			case (width)
				W8: begin
					for (int i = 0; i < `VEC_BITS / 16; i++) begin
						result.h[i] = op_a.b[2 * i + int'(odd)] * op_m.b[2 * i + int'(odd)];
					end
				end
				W16: begin
					for (int i = 0; i < `VEC_BITS / 32; i++) begin
						result.w[i] = op_a.h[2 * i + int'(odd)] * op_m.h[2 * i + int'(odd)];
					end
				end
				W32: begin
					result.d[0] = op_a.w[int'(odd)] * op_m.w[int'(odd)];
				end
				default: begin
					// No 128 bit product, result stays zero
					result = '0;
				end
			endcase
		end
	end

endmodule

/* logic/vec_result_stage.sv */
module vec_result_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  vec_alu_pkg::vec_word_u logic_result,
	input  logic                   logic_claim,
	input  vec_alu_pkg::vec_word_u mul_result,
	input  logic                   mul_claim,
	output logic                   out_valid,
	output vec_alu_pkg::vec_word_u out_result
);

	import vec_alu_pkg::*;

	vec_word_u sel_word;

	// Claims are exclusive, unclaimed codes give zero
	always_comb begin
		if (logic_claim) begin
			sel_word = logic_result;
		end else if (mul_claim) begin
			sel_word = mul_result;
		end else begin
			sel_word = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_result <= '0;
		end else begin
			out_valid <= in_valid;
			// Hold the last result across gaps
			if (in_valid) begin
				out_result <= sel_word;
			end
		end
	end

endmodule

/* logic/vec_alu.sv */
module vec_alu (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  vec_alu_pkg::func_e       func,
	input  vec_alu_pkg::lane_width_e width,
	input  vec_alu_pkg::vec_word_u   op_a,
	input  vec_alu_pkg::vec_word_u   op_b,
	output logic                     out_valid,
	output vec_alu_pkg::vec_word_u   out_result
);

	import vec_alu_pkg::*;

	vec_word_u logic_result;
	logic      logic_claim;
	vec_word_u mul_result;
	logic      mul_claim;

	// Both units see every operation and decode func themselves
	lane_logic_unit u_logic (
		.func   (func),
		.width  (width),
		.op_a   (op_a),
		.op_b   (op_b),
		.result (logic_result),
		.claim  (logic_claim)
	);

	lane_mul_unit u_mul (
		.func   (func),
		.width  (width),
		.op_a   (op_a),
		.op_b   (op_b),
		.result (mul_result),
		.claim  (mul_claim)
	);

	// Single register stage, one cycle latency
	vec_result_stage u_result (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.logic_result (logic_result),
		.logic_claim  (logic_claim),
		.mul_result   (mul_result),
		.mul_claim    (mul_claim),
		.out_valid    (out_valid),
		.out_result   (out_result)
	);

endmodule

/* tb/vec_alu_model.svh */
`ifndef VEC_ALU_MODEL_SVH
`define VEC_ALU_MODEL_SVH

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic [31:0] n;

	n = s >> 1;
	if (s[0]) begin
		n = n ^ 32'h8020_0003;
	end
	return n;
endfunction

// Ones in the low w bits
function automatic logic [`VEC_BITS-1:0] low_mask(input int w);
	if (w >= `VEC_BITS) begin
		return '1;
	end else begin
		return (64'd1 << w) - 64'd1;
	end
endfunction

// One lane, value right aligned
function automatic logic [`VEC_BITS-1:0] lane_model(
	input logic [5:0]           f,
	input int                   w,
	input logic [`VEC_BITS-1:0] a,
	input logic [`VEC_BITS-1:0] b
);
	logic [`VEC_BITS-1:0] m;
	logic [`VEC_BITS-1:0] r;
	int                   sh;

	m = low_mask(w);
	sh = int'(b & 64'(w - 1));
	r = '0;
	case (f)
		VADD: begin
			r = (a + b) & m;
		end
		VSUB: begin
			r = (a - b) & m;
		end
		VSLL: begin
			r = (a << sh) & m;
		end
		VSRL: begin
			r = a >> sh;
		end
		VSRA: begin
			r = a >> sh;
			// Top sh bits of the lane take the sign
			if (a[w - 1]) begin
				r = r | (m & ~(m >> sh));
			end
		end
		VRTTH: begin
			// Low half moves up, high half moves down
			r = ((a & (m >> (w / 2))) << (w / 2)) | ((a >> (w / 2)) & (m >> (w / 2)));
		end
		default: begin
			r = '0;
		end
	endcase
	return r;
endfunction

// Expected output word for one item
function automatic logic [`VEC_BITS-1:0] ref_word(
	input logic [5:0]           f,
	input logic [1:0]           ww,
	input logic [`VEC_BITS-1:0] a,
	input logic [`VEC_BITS-1:0] b
);
	logic [`VEC_BITS-1:0] r;
	logic [`VEC_BITS-1:0] m;
	logic [`VEC_BITS-1:0] la;
	logic [`VEC_BITS-1:0] lb;
	int                   w;
	int                   pos;
	int                   src;

	r = '0;
	w = 8 << ww;
	m = low_mask(w);
	case (f)
		VAND: begin
			r = a & b;
		end
		VOR: begin
			r = a | b;
		end
		VXOR: begin
			r = a ^ b;
		end
		VNOT: begin
			r = ~a;
		end
		VMOV: begin
			r = a;
		end
		VADD, VSUB, VSLL, VSRL, VSRA, VRTTH: begin
			for (int i = 0; i < `VEC_BITS / w; i++) begin
				pos = `VEC_BITS - (i + 1) * w;
				la = (a >> pos) & m;
				lb = (b >> pos) & m;
				r = r | (lane_model(f, w, la, lb) << pos);
			end
		end
		VMULEU, VMULOU, VSQEU, VSQOU: begin
			// 64 bit lanes have no wider view to hold the product
			if (w < `VEC_BITS) begin
				for (int i = 0; i < `VEC_BITS / (2 * w); i++) begin
					src = 2 * i + ((f == VMULOU || f == VSQOU) ? 1 : 0);
					pos = `VEC_BITS - (src + 1) * w;
					la = (a >> pos) & m;
					lb = (f == VSQEU || f == VSQOU) ? la : ((b >> pos) & m);
					r = r | ((la * lb) << (`VEC_BITS - (i + 1) * 2 * w));
				end
			end
		end
		default: begin
			r = '0;
		end
	endcase
	return r;
endfunction

`endif

/* tb/tb_vec_alu.sv */
`include "vec_alu_defines.svh"

module tb_vec_alu;

	import vec_alu_pkg::*;

	`include "vec_alu_model.svh"

	localparam int NUM_ITEMS = 2000;
	localparam int RESET_CYCLES = 5;
	localparam int CYCLE_LIMIT = NUM_ITEMS + RESET_CYCLES + 50;
	localparam int NUM_CODES = 22;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	func_e       func;
	lane_width_e width;
	vec_word_u   op_a;
	vec_word_u   op_b;
	logic        out_valid;
	vec_word_u   out_result;

	logic [31:0] lfsr_state;
	vec_word_u   exp_queue[$];
	vec_word_u   last_result;
	logic        pend_valid;
	logic        pend_reset;
	int          cycle_count;
	int          code;
	logic [1:0]  ww;

	// Supported codes, then divide, modulo, square root and spare codes
	int func_codes[NUM_CODES] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 16, 17,
		14, 15, 18, 19, 40, 63};

	vec_alu uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.func       (func),
		.width      (width),
		.op_a       (op_a),
		.op_b       (op_b),
		.out_valid  (out_valid),
		.out_result (out_result)
	);

	always #2 clk = ~clk;

	// One LFSR step per bit taken
	function automatic logic [63:0] take_bits(input int n);
		logic [63:0] v;

		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_result(input vec_word_u got, input vec_word_u exp);
		if (got !== exp) begin
			stop_with_error($sformatf("CHECK FAILED out_result: got %h expected %h",
				got.d[0], exp.d[0]));
		end
	endtask

	task automatic check_valid(input logic got, input logic exp);
		if (got !== exp) begin
			stop_with_error($sformatf("CHECK FAILED out_valid: got %h expected %h", got, exp));
		end
	endtask

	// Sampled mid-cycle, inputs change just after the rising edge
	always @(negedge clk) begin
		// Flops are unknown until the first rising edge
		if (cycle_count > 0) begin
			if (pend_reset) begin
				last_result = '0;
			end
			check_valid(out_valid, pend_valid);
			if (out_valid) begin
				if (exp_queue.size() == 0) begin
					stop_with_error("A result came out with no item pending");
				end else begin
					last_result = exp_queue.pop_front();
				end
			end
			check_result(out_result, last_result);
			pend_valid = rst_n & in_valid;
			pend_reset = !rst_n;
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			stop_with_error($sformatf("Timeout after %0d cycles with %0d results still pending",
				cycle_count, exp_queue.size()));
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		func = VNOP;
		width = W8;
		op_a = '0;
		op_b = '0;
		lfsr_state = 32'd58;
		cycle_count = 0;
		last_result = '0;
		pend_valid = 1'b0;
		pend_reset = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int n = 0; n < NUM_ITEMS; n++) begin
			// About one cycle in four left idle
			in_valid = (take_bits(2) != 0);
			code = func_codes[take_bits(5) % NUM_CODES];
			ww = take_bits(2);
			func = func_e'(code);
			width = lane_width_e'(ww);
			op_a = vec_word_u'(take_bits(64));
			op_b = vec_word_u'(take_bits(64));
			if (in_valid) begin
				exp_queue.push_back(vec_word_u'(ref_word(code[5:0], ww, op_a, op_b)));
			end
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;

		// Let the last result drain
		repeat (3) @(posedge clk);
		@(negedge clk);
		#1;
		if (exp_queue.size() != 0) begin
			stop_with_error($sformatf("%0d results never came out", exp_queue.size()));
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

/* vec_alu.f */
+incdir+logic
+incdir+tb
logic/vec_alu_pkg.sv
logic/lane_logic_unit.sv
logic/lane_mul_unit.sv
logic/vec_result_stage.sv
logic/vec_alu.sv
tb/tb_vec_alu.sv
